// ==== sim.f ====
+incdir+hw
hw/cache_pkg.sv
hw/cache_tag_array.sv
hw/cache_data_array.sv
hw/cache_fill_fsm.sv
hw/cache.sv
hw/main_memory.sv
hw/cache_subsystem.sv
dv/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cache_tb -f sim.f

output=$(./obj_dir/Vcache_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// ==== dv/cache_testdata.txt ====
// op addr wdata hit rdata: op 0 read, 1 write, ffff ends the list
// hit is expected in the first cycle, rdata is checked on reads only
1 0010 1111 0 0000 // new block, write miss, fill, then write hit
1 0012 2222 1 0000
1 0014 3333 1 0000
1 0016 4444 1 0000
1 0018 5555 1 0000
1 001a 6666 1 0000
1 001c 7777 1 0000
1 001e 8888 1 0000
0 0010 0000 1 1111 // read hits on the filled block
0 0016 0000 1 4444
0 001e 0000 1 8888
0 0011 0000 1 1111 // byte bit ignored
1 0814 abcd 0 0000 // same set, other tag, evicts
0 0814 0000 1 abcd
0 0016 0000 0 4444 // refill from memory after write-through
0 0010 0000 1 1111
0 0814 0000 0 abcd
0 001c 0000 0 7777
1 0018 5a5a 1 0000 // one word changed
0 0016 0000 1 4444
0 001a 0000 1 6666
0 0018 0000 1 5a5a
1 7ffe beef 0 0000 // last set, tag 0f
0 7ffe 0000 1 beef
0 0018 0000 1 5a5a
ffff 0000 0000 0 0000

// ==== dv/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_tb;

	localparam int DEPTH = 256; // testdata words for an 8-bit index
	localparam int FIELDS = 5; // op, addr, write data, hit, read data
	localparam int MAX_LINES = DEPTH / FIELDS;
	localparam logic [15:0] END_MARK = 16'hffff; // op value that ends the list

	logic clk;
	logic reset;
	logic mem_read;
	logic mem_write;
	cache_pkg::addr_t addr;
	cache_pkg::word_t write_data;
	cache_pkg::word_t read_data;
	logic stall;
	logic hit;

	logic [15:0] testdata [0:DEPTH-1]; // flat list of request fields
	int line_count;
	int cycle_count;
	int cycle_limit; // set once the testdata is counted
	logic [31:0] lcg_state; // idle gap source

	cache_subsystem cache_subsystem_inst (
		.clk(clk),
		.reset(reset),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.addr(addr),
		.write_data(write_data),
		.read_data(read_data),
		.stall(stall),
		.hit(hit)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period

	// run limit scales with the number of requests
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: requests still pending after %0d cycles", cycle_count);
			$display("SIMULATION FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// field col of testdata line n
	function automatic logic [15:0] field_of(input int line, input int col);
		logic [7:0] pos;
		pos = 8'(line * FIELDS + col);
		return testdata[pos];
	endfunction

	task automatic check(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected 0x%h actual 0x%h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic drive_idle();
		mem_read = 1'b0;
		mem_write = 1'b0;
		addr = '0;
		write_data = '0;
	endtask

	initial begin
		int gap;
		cycle_count = 0;
		line_count = 0;
		lcg_state = 32'hac2d4021;
		reset = 1'b1;
		drive_idle();

		$readmemh("dv/cache_testdata.txt", testdata);
		while (line_count < MAX_LINES && field_of(line_count, 0) != END_MARK) begin
			line_count++;
		end
		// a miss costs about 8 memory round trips plus room for gaps
		cycle_limit = line_count * (8 * (`CACHE_MEM_LATENCY + 2) + 10) + 100;
		if (line_count == 0 || line_count == MAX_LINES) begin
			$display("testdata file is empty or has no end marker line");
			$display("SIMULATION FAILED");
			$fatal(1, "bad testdata file");
		end

		repeat (3) @(posedge clk); // reset over 3 edges
		#1;
		reset = 1'b0;

		// no fill and no match while idle after reset
		@(negedge clk);
		check("stall", 16'h0000, 16'(stall));
		check("hit", 16'h0000, 16'(hit));
		@(posedge clk);
		#1;

		for (int n = 0; n < line_count; n++) begin
			mem_read = (field_of(n, 0) == 16'h0000);
			mem_write = (field_of(n, 0) == 16'h0001);
			addr = field_of(n, 1);
			write_data = field_of(n, 2);

			@(negedge clk); // first cycle with outputs settled
			check("hit", field_of(n, 3), 16'(hit));
			check("stall", 16'h0000, 16'(stall)); // stall only rises the edge after
			if (!hit) begin
				@(negedge clk);
				check("stall", 16'h0001, 16'(stall)); // fill started
			end
			while (stall || !hit) begin
				@(negedge clk); // request held until the fill is done
			end
			if (mem_read) begin
				check("read_data", field_of(n, 4), read_data); // data in the accept cycle
			end

			@(posedge clk); // write lands on this edge
			#1;
			drive_idle();
			lcg_state = next_random(lcg_state);
			gap = int'(lcg_state[17:16]); // 0 to 3 idle cycles
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem (
	input wire logic clk,
	input wire logic reset,
	input wire logic mem_read, // pipeline load
	input wire logic mem_write, // pipeline store
	input wire cache_pkg::addr_t addr, // held while stall is high
	input wire cache_pkg::word_t write_data,
	output cache_pkg::word_t read_data, // valid when a load is accepted
	output logic stall, // fill in progress
	output logic hit // tag match on the current request
);

	logic cache_mem_read;
	logic cache_mem_write;
	cache_pkg::addr_t cache_mem_read_addr;
	cache_pkg::addr_t cache_mem_write_addr;
	cache_pkg::word_t cache_mem_write_data;
	logic mem_data_valid;
	cache_pkg::word_t mem_read_data;

	cache cache_inst (
		.clk(clk),
		.reset(reset),
		.pipe_mem_read(mem_read),
		.pipe_mem_write(mem_write),
		.pipe_addr(addr),
		.pipe_write_data(write_data),
		.mem_data_valid(mem_data_valid),
		.mem_read_data(mem_read_data),
		.cache_mem_read(cache_mem_read),
		.cache_mem_write(cache_mem_write),
		.cache_mem_read_addr(cache_mem_read_addr),
		.cache_mem_write_addr(cache_mem_write_addr),
		.cache_mem_write_data(cache_mem_write_data),
		.cache_data_out(read_data),
		.stall(stall),
		.cache_hit(hit)
	);

	main_memory main_memory_inst (
		.clk(clk),
		.reset(reset),
		.read(cache_mem_read),
		.read_addr(cache_mem_read_addr),
		.write(cache_mem_write),
		.write_addr(cache_mem_write_addr),
		.write_data(cache_mem_write_data),
		.data_valid(mem_data_valid),
		.read_data(mem_read_data)
	);

endmodule

`default_nettype wire

// ==== hw/main_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module main_memory (
	input wire logic clk,
	input wire logic reset,
	input wire logic read, // one-cycle read request
	input wire cache_pkg::addr_t read_addr, // byte address, bit 0 ignored
	input wire logic write, // single-cycle write
	input wire cache_pkg::addr_t write_addr, // byte address, bit 0 ignored
	input wire cache_pkg::word_t write_data,
	output logic data_valid, // one pulse per read, LATENCY cycles later
	output cache_pkg::word_t read_data // valid while data_valid is high
);

	localparam int WORDS = 1 << `CACHE_MEM_DEPTH_W;
	localparam int CNT_W = $clog2(`CACHE_MEM_LATENCY + 1);

	cache_pkg::word_t words [0:WORDS-1]; // no defined initial contents
	logic [CNT_W-1:0] count_q; // cycles left until the answer, 0 when idle
	logic [`CACHE_MEM_DEPTH_W-1:0] read_word_q; // word address of the pending read

	// latency counter, only one read outstanding
	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= '0;
			data_valid <= 1'b0;
		end else begin
			if (read) begin
				count_q <= CNT_W'(`CACHE_MEM_LATENCY - 1); // data_valid lands LATENCY cycles on
			end else if (count_q != '0) begin
				count_q <= count_q - 1'b1;
			end
			data_valid <= (count_q == CNT_W'(1)); // one-cycle pulse
		end
	end

	// pending read address
	always_ff @(posedge clk) begin
		if (read) begin
			read_word_q <= read_addr[`CACHE_ADDR_W-1:1];
		end
	end

	// data comes out with data_valid, picks up any write made meanwhile
	always_ff @(posedge clk) begin
		if (count_q == CNT_W'(1)) begin
			read_data <= words[read_word_q];
		end
	end

	// writes complete on the edge they are presented
	always_ff @(posedge clk) begin
		if (write) begin
			words[write_addr[`CACHE_ADDR_W-1:1]] <= write_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache (
	input wire logic clk,
	input wire logic reset,
	input wire logic pipe_mem_read, // pipeline load request
	input wire logic pipe_mem_write, // pipeline store request
	input wire cache_pkg::addr_t pipe_addr, // load or store address
	input wire cache_pkg::word_t pipe_write_data, // store data
	input wire logic mem_data_valid, // memory read answer
	input wire cache_pkg::word_t mem_read_data, // word returned by memory
	output logic cache_mem_read, // fill read request
	output logic cache_mem_write, // write-through of a store
	output cache_pkg::addr_t cache_mem_read_addr, // fill word address
	output cache_pkg::addr_t cache_mem_write_addr, // store address to memory
	output cache_pkg::word_t cache_mem_write_data, // store data to memory
	output cache_pkg::word_t cache_data_out, // word read from the cache
	output logic stall, // hold the pipeline during a fill
	output logic cache_hit // tag match on a present request
);

	cache_pkg::tag_t tag; // addr[15:11]
	cache_pkg::index_t index; // addr[10:4]
	cache_pkg::offset_t offset; // addr[3:1], addr[0] ignored

	logic request; // load or store present
	logic tag_valid;
	cache_pkg::tag_t stored_tag;
	logic tag_match;
	logic miss;
	logic write_hit; // store accepted this cycle

	logic fill_busy;
	cache_pkg::offset_t fill_offset;
	logic fill_write;
	logic tag_write;

	cache_pkg::offset_t array_offset; // word select into the data array
	cache_pkg::word_t array_data_in;
	logic array_write;

	// address split
	assign tag = pipe_addr[`CACHE_ADDR_W-1:`CACHE_ADDR_W-`CACHE_TAG_W];
	assign index = pipe_addr[`CACHE_INDEX_W+`CACHE_OFFSET_W:`CACHE_OFFSET_W+1];
	assign offset = pipe_addr[`CACHE_OFFSET_W:1];

	// hit detection
	assign request = pipe_mem_read | pipe_mem_write;
	assign tag_match = tag_valid && (stored_tag == tag);
	assign cache_hit = request && tag_match;
	assign miss = request && !tag_match && !fill_busy; // fill engine only sees it while idle
	assign write_hit = pipe_mem_write && tag_match && !fill_busy;

	cache_tag_array tag_array_inst (
		.clk(clk),
		.reset(reset),
		.index(index),
		.tag_in(tag), // request is held, so this is the filled block's tag
		.write(tag_write),
		.valid(tag_valid),
		.tag_out(stored_tag)
	);

	cache_fill_fsm fill_fsm_inst (
		.clk(clk),
		.reset(reset),
		.miss(miss),
		.miss_addr(pipe_addr),
		.mem_data_valid(mem_data_valid),
		.busy(fill_busy),
		.fill_offset(fill_offset),
		.fill_write(fill_write),
		.tag_write(tag_write),
		.mem_read(cache_mem_read),
		.mem_read_addr(cache_mem_read_addr)
	);

	// fill engine owns the data array while busy, pipeline otherwise
	assign array_offset = fill_busy ? fill_offset : offset;
	assign array_data_in = fill_busy ? mem_read_data : pipe_write_data;
	assign array_write = fill_write | write_hit;

	cache_data_array data_array_inst (
		.clk(clk),
		.index(index),
		.offset(array_offset),
		.write(array_write),
		.data_in(array_data_in),
		.data_out(cache_data_out)
	);

	// write-through, memory takes the store on the same edge as the array
	assign cache_mem_write = write_hit;
	assign cache_mem_write_addr = pipe_addr;
	assign cache_mem_write_data = pipe_write_data;

	assign stall = fill_busy; // rises the edge after a miss is seen

endmodule

`default_nettype wire

// ==== hw/cache_fill_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_fill_fsm (
	input wire logic clk,
	input wire logic reset,
	input wire logic miss, // tag mismatch on a pending request
	input wire cache_pkg::addr_t miss_addr, // address of the missing request
	input wire logic mem_data_valid, // memory answers the last read
	output logic busy, // fill in progress, stalls the pipeline
	output cache_pkg::offset_t fill_offset, // word being filled
	output logic fill_write, // write the returned word into the data array
	output logic tag_write, // last word in, set tag and valid
	output logic mem_read, // one-cycle read request to memory
	output cache_pkg::addr_t mem_read_addr // byte address of the word being fetched
);

	localparam int BLOCK_W = `CACHE_ADDR_W - `CACHE_OFFSET_W - 1; // tag + index bits

	cache_pkg::fill_state_t state_q;
	cache_pkg::fill_state_t state_d;
	cache_pkg::offset_t offset_q; // next word to fetch
	logic [BLOCK_W-1:0] block_q; // tag and index of the block being filled
	logic last_word; // offset is at word seven

	assign last_word = (offset_q == {`CACHE_OFFSET_W{1'b1}});

	// next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_pkg::FILL_IDLE: begin
				if (miss) begin
					state_d = cache_pkg::FILL_REQUEST;
				end
			end
			cache_pkg::FILL_REQUEST: begin
				state_d = cache_pkg::FILL_WAIT; // request lasts one cycle
			end
			cache_pkg::FILL_WAIT: begin
				if (mem_data_valid) begin
					// go fetch the next word, or wrap up after word seven
					state_d = last_word ? cache_pkg::FILL_FINISH : cache_pkg::FILL_REQUEST;
				end
			end
			cache_pkg::FILL_FINISH: begin
				state_d = cache_pkg::FILL_IDLE; // tag written this cycle
			end
			default: begin
				state_d = cache_pkg::FILL_IDLE;
			end
		endcase
	end

	// state and word counter
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= cache_pkg::FILL_IDLE;
			offset_q <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == cache_pkg::FILL_IDLE) begin
				offset_q <= '0; // every fill starts at word zero
			end else if (fill_write) begin
				offset_q <= offset_q + 1'b1; // advance after each returned word
			end
		end
	end

	// block base is taken once at the start of the miss
	always_ff @(posedge clk) begin
		if (state_q == cache_pkg::FILL_IDLE && miss) begin
			block_q <= miss_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W+1];
		end
	end

	assign busy = (state_q != cache_pkg::FILL_IDLE);
	assign mem_read = (state_q == cache_pkg::FILL_REQUEST);
	assign fill_write = (state_q == cache_pkg::FILL_WAIT) && mem_data_valid;
	assign tag_write = (state_q == cache_pkg::FILL_FINISH);
	assign fill_offset = offset_q;
	assign mem_read_addr = {block_q, offset_q, 1'b0}; // word aligned, byte bit zero

endmodule

`default_nettype wire

// ==== hw/cache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_data_array (
	input wire logic clk,
	input wire cache_pkg::index_t index, // block select
	input wire cache_pkg::offset_t offset, // word select inside the block
	input wire logic write, // write data_in to the addressed word
	input wire cache_pkg::word_t data_in, // fill word or pipeline store data
	output cache_pkg::word_t data_out // addressed word, combinational
);

	localparam int WORDS = 1 << (`CACHE_INDEX_W + `CACHE_OFFSET_W); // 128 blocks x 8 words

	logic [`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] word_addr; // flat word address

	cache_pkg::word_t words [0:WORDS-1]; // block storage, no reset

	// block n occupies words 8n..8n+7
	assign word_addr = {index, offset};

	// single-word write, one port
	always_ff @(posedge clk) begin
		if (write) begin
			words[word_addr] <= data_in;
		end
	end

	// read is asynchronous so a read hit returns data the same cycle
	assign data_out = words[word_addr];

endmodule

`default_nettype wire

// ==== hw/cache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_tag_array (
	input wire logic clk,
	input wire logic reset,
	input wire cache_pkg::index_t index, // set being looked up or written
	input wire cache_pkg::tag_t tag_in, // tag of the block just filled
	input wire logic write, // store tag_in and mark the set valid
	output logic valid, // set holds a block
	output cache_pkg::tag_t tag_out // tag of the block in that set
);

	localparam int SETS = 1 << `CACHE_INDEX_W;

	logic [SETS-1:0] valid_q; // one valid bit per set, cleared on reset
	cache_pkg::tag_t tags [0:SETS-1]; // tag storage, guarded by valid_q

	// valid bits are control state
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0; // every set empty after reset
		end else if (write) begin
			valid_q[index] <= 1'b1; // block fully filled
		end
	end

	// tags only matter once the valid bit is set
	always_ff @(posedge clk) begin
		if (write) begin
			tags[index] <= tag_in;
		end
	end

	// asynchronous lookup so the hit check fits in one cycle
	assign valid = valid_q[index];
	assign tag_out = tags[index];

endmodule

`default_nettype wire

// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	`include "cache_settings.svh"

	typedef logic [`CACHE_ADDR_W-1:0] addr_t; // byte address
	typedef logic [`CACHE_WORD_W-1:0] word_t; // data word
	typedef logic [`CACHE_TAG_W-1:0] tag_t; // upper address bits kept per set
	typedef logic [`CACHE_INDEX_W-1:0] index_t; // set select
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t; // word within block

	// miss handler states
	typedef enum logic [1:0] {
		FILL_IDLE, // no miss in progress
		FILL_REQUEST, // pulse one memory read
		FILL_WAIT, // wait for the word to come back
		FILL_FINISH // all words in, set tag and valid
	} fill_state_t;

endpackage

`default_nettype wire

// ==== hw/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address and data widths
`define CACHE_ADDR_W 16 // byte address
`define CACHE_WORD_W 16 // one data word

// cache geometry, 5-bit tag + 7-bit set + 3-bit word + byte bit
`define CACHE_TAG_W 5 // addr[15:11]
`define CACHE_INDEX_W 7 // addr[10:4], 128 sets
`define CACHE_OFFSET_W 3 // addr[3:1], 8 words per block

// main memory
`define CACHE_MEM_LATENCY 4 // cycles from read pulse to data_valid, at least 2
`define CACHE_MEM_DEPTH_W 15 // word address, covers the full 64 KiB

`endif
